//--- axil_pkg.sv
package axil_pkg;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // master to slave
  typedef struct packed {
    logic                   awvalid;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

endpackage

//--- axil_reg_slave.sv
`timescale 1ns/1ps

module axil_reg_slave (
  input  logic                                             clk_125,
  input  logic                                             sys_rst,
  input  axil_pkg::axil_req_t                              axil_req_i,
  output axil_pkg::axil_rsp_t                              axil_rsp_o,
  output ethpipe_regs_pkg::reg_req_t                       reg_req_o,
  input  logic [ethpipe_regs_pkg::REG_DATA_W-1:0]          reg_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRESP,
    ST_RWAIT,
    ST_RRESP
  } state_t;

  state_t state_q;

  logic wr_both;
  logic wr_accept;
  logic rd_accept;

  logic                                        req_valid_q;
  logic                                        req_write_q;
  logic [ethpipe_regs_pkg::REG_ADDR_W-1:0]     req_addr_q;
  logic [ethpipe_regs_pkg::REG_DATA_W-1:0]     req_wdata_q;
  logic [ethpipe_regs_pkg::REG_STRB_W-1:0]     req_strb_q;
  logic                                        bvalid_q;
  logic [axil_pkg::AXIL_DATA_W-1:0]            rdata_q;

  // aw and w are only taken together, writes win over reads
  assign wr_both   = axil_req_i.awvalid && axil_req_i.wvalid;
  assign wr_accept = (state_q == ST_IDLE) && wr_both;
  assign rd_accept = (state_q == ST_IDLE) && axil_req_i.arvalid && !wr_both;

  // ----------------------------------------
  // handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      state_q     <= ST_IDLE;
      req_valid_q <= 1'b0;
      bvalid_q    <= 1'b0;
    end else begin
      req_valid_q <= wr_accept || rd_accept;
      case (state_q)
        ST_IDLE: begin
          if (wr_accept) begin
            state_q <= ST_WRESP;
          end else if (rd_accept) begin
            state_q <= ST_RWAIT;
          end
        end
        ST_WRESP: begin
          // register is written on the same edge
          if (req_valid_q) begin
            bvalid_q <= 1'b1;
          end else if (bvalid_q && axil_req_i.bready) begin
            bvalid_q <= 1'b0;
            state_q  <= ST_IDLE;
          end
        end
        ST_RWAIT: begin
          if (!req_valid_q) begin
            state_q <= ST_RRESP;
          end
        end
        ST_RRESP: begin
          if (axil_req_i.rready) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // latched request and read data
  always_ff @(posedge clk_125) begin
    if (wr_accept) begin
      req_write_q <= 1'b1;
      req_addr_q  <= axil_req_i.awaddr[axil_pkg::AXIL_ADDR_W-1:2];
      req_wdata_q <= axil_req_i.wdata;
      req_strb_q  <= axil_req_i.wstrb;
    end else if (rd_accept) begin
      req_write_q <= 1'b0;
      req_addr_q  <= axil_req_i.araddr[axil_pkg::AXIL_ADDR_W-1:2];
    end
    if (state_q == ST_RWAIT && !req_valid_q) begin
      rdata_q <= reg_rdata_i;
    end
  end

  always_comb begin
    reg_req_o.valid = req_valid_q;
    reg_req_o.write = req_write_q;
    reg_req_o.addr  = req_addr_q;
    reg_req_o.wdata = req_wdata_q;
    reg_req_o.strb  = req_strb_q;
  end

  always_comb begin
    axil_rsp_o.awready = wr_accept;
    axil_rsp_o.wready  = wr_accept;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = axil_pkg::RESP_OKAY;
    axil_rsp_o.arready = rd_accept;
    axil_rsp_o.rvalid  = (state_q == ST_RRESP);
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = axil_pkg::RESP_OKAY;
  end

endmodule

//--- ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                                        clk_125,
  input  logic                                        sys_rst,
  input  ethpipe_regs_pkg::reg_req_t                  reg_req_i,
  output logic [ethpipe_regs_pkg::REG_DATA_W-1:0]     reg_rdata_o,
  input  logic [ethpipe_regs_pkg::COUNTER_W-1:0]      counter_i,
  input  ethpipe_regs_pkg::slot_array_t               slots_i,
  input  logic                                        intr_flag_i,
  output logic                                        intr_ack_o,
  output logic [ethpipe_regs_pkg::MOD_W-1:0]          clr_val_o,
  output logic [ethpipe_regs_pkg::MOD_W-1:0]          set_val_o,
  output logic [ethpipe_regs_pkg::STATUS_W-1:0]       led_o
);

  logic [ethpipe_regs_pkg::FLAG_HI_W-1:0]   flags_hi_q;
  logic [ethpipe_regs_pkg::FLAG_LO_W-1:0]   flags_lo_q;
  logic [ethpipe_regs_pkg::MOD_W-1:0]       clr_val_q;
  logic [ethpipe_regs_pkg::MOD_W-1:0]       set_val_q;
  logic [ethpipe_regs_pkg::REG_DATA_W-1:0]  cnt_hi_shadow_q;
  logic [ethpipe_regs_pkg::REG_DATA_W-1:0]  rdata_q;
  logic [ethpipe_regs_pkg::REG_DATA_W-1:0]  rd_word;

  logic [ethpipe_regs_pkg::REG_ADDR_W+1:0]  byte_addr;
  logic [ethpipe_regs_pkg::REG_ADDR_W+1:0]  slot_off;
  logic [ethpipe_regs_pkg::SLOT_IDX_W-1:0]  slot_idx;
  logic [ethpipe_regs_pkg::STAMP_W-1:0]     slot_sel;
  logic                                     slot_hit;
  logic                                     wr_en;
  logic                                     rd_en;

  ethpipe_regs_pkg::status_t status_cur;
  ethpipe_regs_pkg::status_t status_wr;

  assign byte_addr = {reg_req_i.addr, 2'b00};
  assign wr_en     = reg_req_i.valid && reg_req_i.write;
  assign rd_en     = reg_req_i.valid && !reg_req_i.write;
  assign status_wr = ethpipe_regs_pkg::status_t'(
                       reg_req_i.wdata[ethpipe_regs_pkg::STATUS_W-1:0]);

  // interrupt bit comes from the moderator
  always_comb begin
    status_cur.flags_hi = flags_hi_q;
    status_cur.intr     = intr_flag_i;
    status_cur.flags_lo = flags_lo_q;
  end

  // host writes 0 to the intr bit to acknowledge
  assign intr_ack_o = wr_en && (byte_addr == ethpipe_regs_pkg::ADDR_STATUS) &&
                      reg_req_i.strb[0] && !status_wr.intr;

  // ----------------------------------------
  // register writes
  // ----------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      flags_hi_q      <= '0;
      flags_lo_q      <= '0;
      clr_val_q       <= ethpipe_regs_pkg::CLR_INTR_RST;
      set_val_q       <= ethpipe_regs_pkg::SET_INTR_RST;
      cnt_hi_shadow_q <= '0;
    end else begin
      if (wr_en && byte_addr == ethpipe_regs_pkg::ADDR_STATUS && reg_req_i.strb[0]) begin
        flags_hi_q <= status_wr.flags_hi;
        flags_lo_q <= status_wr.flags_lo;
      end
      for (int b = 0; b < ethpipe_regs_pkg::REG_STRB_W; b++) begin
        if (wr_en && reg_req_i.strb[b]) begin
          if (byte_addr == ethpipe_regs_pkg::ADDR_CLR_VAL) begin
            clr_val_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
          end
          if (byte_addr == ethpipe_regs_pkg::ADDR_SET_VAL) begin
            set_val_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
          end
        end
      end
      // low word read freezes the high word
      if (rd_en && byte_addr == ethpipe_regs_pkg::ADDR_CNT_LO) begin
        cnt_hi_shadow_q <= counter_i[ethpipe_regs_pkg::COUNTER_W-1:
                                     ethpipe_regs_pkg::REG_DATA_W];
      end
    end
  end

  // ----------------------------------------
  // read mux
  // ----------------------------------------
  assign slot_off = byte_addr - ethpipe_regs_pkg::ADDR_SLOT_BASE;
  assign slot_idx = slot_off[3 +: ethpipe_regs_pkg::SLOT_IDX_W];
  assign slot_sel = slots_i[slot_idx];
  assign slot_hit = (byte_addr >= ethpipe_regs_pkg::ADDR_SLOT_BASE) &&
                    (slot_off < 8 * ethpipe_regs_pkg::NUM_SLOTS);

  always_comb begin
    rd_word = '0;
    case (byte_addr)
      ethpipe_regs_pkg::ADDR_STATUS:  rd_word[ethpipe_regs_pkg::STATUS_W-1:0] = status_cur;
      ethpipe_regs_pkg::ADDR_CNT_LO:  rd_word = counter_i[ethpipe_regs_pkg::REG_DATA_W-1:0];
      ethpipe_regs_pkg::ADDR_CNT_HI:  rd_word = cnt_hi_shadow_q;
      ethpipe_regs_pkg::ADDR_CLR_VAL: rd_word = clr_val_q;
      ethpipe_regs_pkg::ADDR_SET_VAL: rd_word = set_val_q;
      default: begin
        if (slot_hit) begin
          // odd word of a slot holds the top 16 bits
          if (slot_off[2]) begin
            rd_word[ethpipe_regs_pkg::STAMP_W-ethpipe_regs_pkg::REG_DATA_W-1:0] =
              slot_sel[ethpipe_regs_pkg::STAMP_W-1:ethpipe_regs_pkg::REG_DATA_W];
          end else begin
            rd_word = slot_sel[ethpipe_regs_pkg::REG_DATA_W-1:0];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_125) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  assign reg_rdata_o = rdata_q;
  assign clr_val_o   = clr_val_q;
  assign set_val_o   = set_val_q;
  assign led_o       = ~status_cur;

endmodule

//--- ethpipe_ctrl_top.sv
`timescale 1ns/1ps

module ethpipe_ctrl_top (
  input  logic                                    clk_125,
  input  logic                                    sys_rst,
  input  axil_pkg::axil_req_t                     axil_req_i,
  output axil_pkg::axil_rsp_t                     axil_rsp_o,
  input  logic                                    event_req_i,
  input  logic [ethpipe_regs_pkg::NUM_SLOTS-1:0]  time_req_i,
  output logic                                    sys_intr_o,
  output logic [ethpipe_regs_pkg::STATUS_W-1:0]   led_o
);

  ethpipe_regs_pkg::reg_req_t               reg_req;
  logic [ethpipe_regs_pkg::REG_DATA_W-1:0]  reg_rdata;
  logic [ethpipe_regs_pkg::COUNTER_W-1:0]   counter;
  ethpipe_regs_pkg::slot_array_t            slots;
  logic                                     intr_flag;
  logic                                     intr_ack;
  logic [ethpipe_regs_pkg::MOD_W-1:0]       clr_val;
  logic [ethpipe_regs_pkg::MOD_W-1:0]       set_val;

  axil_reg_slave i_axil_reg_slave (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .reg_req_o   (reg_req),
    .reg_rdata_i (reg_rdata)
  );

  ctrl_regs i_ctrl_regs (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .reg_req_i   (reg_req),
    .reg_rdata_o (reg_rdata),
    .counter_i   (counter),
    .slots_i     (slots),
    .intr_flag_i (intr_flag),
    .intr_ack_o  (intr_ack),
    .clr_val_o   (clr_val),
    .set_val_o   (set_val),
    .led_o       (led_o)
  );

  intr_moderator i_intr_moderator (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .event_req_i (event_req_i),
    .intr_ack_i  (intr_ack),
    .clr_val_i   (clr_val),
    .set_val_i   (set_val),
    .intr_flag_o (intr_flag)
  );

  time_capture i_time_capture (
    .clk_125    (clk_125),
    .sys_rst    (sys_rst),
    .time_req_i (time_req_i),
    .counter_o  (counter),
    .slots_o    (slots)
  );

  assign sys_intr_o = intr_flag;

endmodule

//--- ethpipe_regs_pkg.sv
package ethpipe_regs_pkg;

  // ----------------------------------------
  // counter and timestamp slots
  // ----------------------------------------
  localparam int COUNTER_W      = 64;
  localparam int STAMP_W        = 48;
  localparam int NUM_SLOTS      = 4;
  localparam int SLOT_IDX_W     = $clog2(NUM_SLOTS);
  // two-stage request path ahead of the service edge
  localparam int CAPTURE_OFFSET = 2;

  // ----------------------------------------
  // status and interrupt moderation
  // ----------------------------------------
  localparam int STATUS_W  = 8;
  localparam int INTR_BIT  = 3;
  localparam int FLAG_HI_W = STATUS_W - INTR_BIT - 1;
  localparam int FLAG_LO_W = INTR_BIT;
  localparam int MOD_W     = 32;

  localparam logic [MOD_W-1:0] CLR_INTR_RST = 32'd2_500_000;
  localparam logic [MOD_W-1:0] SET_INTR_RST = 32'd2_500_000;

  // ----------------------------------------
  // register access and byte offsets
  // ----------------------------------------
  localparam int REG_ADDR_W = 6;
  localparam int REG_DATA_W = 32;
  localparam int REG_STRB_W = REG_DATA_W / 8;

  localparam logic [REG_ADDR_W+1:0] ADDR_STATUS    = 8'h00;
  localparam logic [REG_ADDR_W+1:0] ADDR_CNT_LO    = 8'h04;
  localparam logic [REG_ADDR_W+1:0] ADDR_CNT_HI    = 8'h08;
  localparam logic [REG_ADDR_W+1:0] ADDR_CLR_VAL   = 8'h10;
  localparam logic [REG_ADDR_W+1:0] ADDR_SET_VAL   = 8'h14;
  localparam logic [REG_ADDR_W+1:0] ADDR_SLOT_BASE = 8'h20;

  typedef struct packed {
    logic [FLAG_HI_W-1:0] flags_hi;
    logic                 intr;
    logic [FLAG_LO_W-1:0] flags_lo;
  } status_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
    logic [REG_STRB_W-1:0] strb;
  } reg_req_t;

  typedef logic [NUM_SLOTS-1:0][STAMP_W-1:0] slot_array_t;

endpackage

//--- flist.f
+incdir+.
ethpipe_regs_pkg.sv
axil_pkg.sv
axil_reg_slave.sv
ctrl_regs.sv
intr_moderator.sv
time_capture.sv
ethpipe_ctrl_top.sv
tb_ethpipe_ctrl.sv

//--- intr_moderator.sv
`timescale 1ns/1ps

module intr_moderator (
  input  logic                                clk_125,
  input  logic                                sys_rst,
  input  logic                                event_req_i,
  input  logic                                intr_ack_i,
  input  logic [ethpipe_regs_pkg::MOD_W-1:0]  clr_val_i,
  input  logic [ethpipe_regs_pkg::MOD_W-1:0]  set_val_i,
  output logic                                intr_flag_o
);

  logic                               flag_q;
  logic [ethpipe_regs_pkg::MOD_W-1:0] hold_off_q;
  logic [ethpipe_regs_pkg::MOD_W-1:0] hold_cnt_q;
  logic                               hold_off_done;

  assign hold_off_done = (hold_off_q == '0);

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      flag_q     <= 1'b0;
      hold_off_q <= '0;
      hold_cnt_q <= '0;
    end else if (intr_ack_i) begin
      // ack starts the hold-off window
      flag_q     <= 1'b0;
      hold_off_q <= clr_val_i;
      hold_cnt_q <= '0;
    end else begin
      if (!hold_off_done) begin
        hold_off_q <= hold_off_q - 1'b1;
      end
      if (event_req_i && hold_off_done) begin
        flag_q     <= 1'b1;
        hold_cnt_q <= '0;
      end else if (flag_q) begin
        // assert time reached
        if (hold_cnt_q == set_val_i) begin
          flag_q <= 1'b0;
        end
        hold_cnt_q <= hold_cnt_q + 1'b1;
      end else begin
        hold_cnt_q <= '0;
      end
    end
  end

  assign intr_flag_o = flag_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ethpipe_ctrl \
  -f flist.f \
  -o tb_ethpipe_ctrl
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_ethpipe_ctrl)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  echo "pass message not found"
  exit 1
fi

//--- tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// ----------------------------------------
// random bits and reporting
// ----------------------------------------
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    val    = {val[30:0], lfsr_q[0]};
    lfsr_q = lfsr_next(lfsr_q);
  end
  return val;
endfunction

function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                            input logic [31:0] new_val,
                                            input logic [3:0]  strb);
  logic [31:0] res;
  res = old_val;
  for (int b = 0; b < 4; b++) begin
    if (strb[b]) begin
      res[8*b +: 8] = new_val[8*b +: 8];
    end
  end
  return res;
endfunction

function automatic void check_eq(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
  assert (act === exp) else begin
    test_errs++;
    $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
  end
endfunction

function automatic void handshake_lost(input string what);
  test_errs++;
  $display("%s: no %s within %0d cycles", cur_test, what, HS_LIMIT);
endfunction

task automatic start_test(input string name);
  cur_test    = name;
  test_errs   = 0;
  assert_base = assert_fails;
endtask

task automatic end_test();
  int errs;
  errs = test_errs + assert_fails - assert_base;
  if (errs == 0) begin
    tests_passed++;
    $display("test %s: passed", cur_test);
  end else begin
    tests_failed++;
    $display("test %s: failed with %0d errors", cur_test, errs);
  end
endtask

// ----------------------------------------
// AXI4-Lite host side
// ----------------------------------------
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
  int waited;
  int delay;
  delay  = int'(rand_bits(2));
  waited = 0;
  @(posedge clk_125);
  axil_req.awvalid <= 1'b1;
  axil_req.awaddr  <= addr;
  axil_req.wvalid  <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.wstrb   <= strb;
  @(negedge clk_125);
  while (!axil_rsp.awready && waited < HS_LIMIT) begin
    @(negedge clk_125);
    waited++;
  end
  if (!axil_rsp.awready) begin
    handshake_lost("awready");
  end
  @(posedge clk_125);
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  waited = 0;
  @(negedge clk_125);
  while (!axil_rsp.bvalid && waited < HS_LIMIT) begin
    @(negedge clk_125);
    waited++;
  end
  if (!axil_rsp.bvalid) begin
    handshake_lost("bvalid");
  end
  repeat (delay) @(posedge clk_125);
  @(posedge clk_125);
  axil_req.bready <= 1'b1;
  @(posedge clk_125);
  axil_req.bready <= 1'b0;
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [63:0] smp);
  int waited;
  int delay;
  delay  = int'(rand_bits(3));
  waited = 0;
  @(posedge clk_125);
  axil_req.arvalid <= 1'b1;
  axil_req.araddr  <= addr;
  @(negedge clk_125);
  while (!axil_rsp.arready && waited < HS_LIMIT) begin
    @(negedge clk_125);
    waited++;
  end
  if (!axil_rsp.arready) begin
    handshake_lost("arready");
  end
  @(posedge clk_125);
  axil_req.arvalid <= 1'b0;
  // cycle in which the register file samples
  @(negedge clk_125);
  smp    = cyc;
  waited = 0;
  while (!axil_rsp.rvalid && waited < HS_LIMIT) begin
    @(negedge clk_125);
    waited++;
  end
  if (!axil_rsp.rvalid) begin
    handshake_lost("rvalid");
  end
  data = axil_rsp.rdata;
  repeat (delay) @(posedge clk_125);
  @(posedge clk_125);
  axil_req.rready <= 1'b1;
  @(posedge clk_125);
  axil_req.rready <= 1'b0;
endtask

`endif

//--- tb_ethpipe_ctrl.sv
`timescale 1ns/1ps

module tb_ethpipe_ctrl;

  localparam int          CLK_PERIOD = 4;
  localparam int          HS_LIMIT   = 32;
  localparam logic [31:0] LFSR_SEED  = 32'h9308a746;
  localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
  localparam logic [31:0] MOD_RST    = 32'd2_500_000;
  // cycle budgets of reset, registers, counter, capture and interrupt tests
  localparam int TEST_CYCLES = 60 + 500 + 120 + 600 + 150;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

  logic                                   clk_125;
  logic                                   sys_rst;
  axil_pkg::axil_req_t                    axil_req;
  axil_pkg::axil_rsp_t                    axil_rsp;
  logic                                   event_req;
  logic [ethpipe_regs_pkg::NUM_SLOTS-1:0] time_req;
  logic                                   sys_intr;
  logic [ethpipe_regs_pkg::STATUS_W-1:0]  led;

  logic [63:0] cyc;
  logic [31:0] lfsr_q;
  string       cur_test;
  int          test_errs;
  int          assert_fails;
  int          assert_base;
  int          tests_passed;
  int          tests_failed;
  logic        aw_hs;
  logic        ar_hs;

  ethpipe_ctrl_top i_ethpipe_ctrl_top (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .event_req_i (event_req),
    .time_req_i  (time_req),
    .sys_intr_o  (sys_intr),
    .led_o       (led)
  );

  always #(CLK_PERIOD / 2) clk_125 = ~clk_125;

  // model of the free-running counter
  always @(posedge clk_125) begin
    if (sys_rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

  `include "tb_axil_tasks.svh"

  function automatic void note_assert_failure(input string what);
    assert_fails++;
    $display("assertion at %0t ns: %s", $time, what);
  endfunction

  // ----------------------------------------
  // handshake assertions
  // ----------------------------------------
  assign aw_hs = axil_req.awvalid && axil_rsp.awready;
  assign ar_hs = axil_req.arvalid && axil_rsp.arready;

  a_resp_okay: assert property (@(posedge clk_125) disable iff (sys_rst)
    !(axil_rsp.bvalid && axil_rsp.bresp != 2'b00) &&
    !(axil_rsp.rvalid && axil_rsp.rresp != 2'b00))
    else note_assert_failure("response code is not OKAY");
  a_bvalid_after_write: assert property (@(posedge clk_125) disable iff (sys_rst)
    $past(aw_hs, 2) |-> (axil_rsp.bvalid && !$past(axil_rsp.bvalid)))
    else note_assert_failure("bvalid did not rise one cycle after write acceptance");
  a_bvalid_cause: assert property (@(posedge clk_125) disable iff (sys_rst)
    $rose(axil_rsp.bvalid) |-> $past(aw_hs, 2))
    else note_assert_failure("bvalid rose without a write two samples earlier");
  a_rvalid_after_read: assert property (@(posedge clk_125) disable iff (sys_rst)
    $past(ar_hs, 3) |-> $rose(axil_rsp.rvalid))
    else note_assert_failure("rvalid did not rise two cycles after the AR handshake");
  a_rvalid_cause: assert property (@(posedge clk_125) disable iff (sys_rst)
    $rose(axil_rsp.rvalid) |-> $past(ar_hs, 3))
    else note_assert_failure("rvalid rose without a read three samples earlier");
  a_r_held: assert property (@(posedge clk_125) disable iff (sys_rst)
    (axil_rsp.rvalid && !axil_req.rready) |=> (axil_rsp.rvalid && $stable(axil_rsp.rdata)))
    else note_assert_failure("read response dropped or changed while stalled");
  a_b_held: assert property (@(posedge clk_125) disable iff (sys_rst)
    (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
    else note_assert_failure("write response dropped while stalled");
  a_led_intr: assert property (@(posedge clk_125) disable iff (sys_rst)
    led[ethpipe_regs_pkg::INTR_BIT] == !sys_intr)
    else note_assert_failure("led interrupt bit does not mirror the inverted flag");

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic reset_and_handshake();
    logic [31:0] wdata;
    logic [31:0] data;
    logic [63:0] smp;
    start_test("reset_handshake");
    check_eq("awready", 64'd0, axil_rsp.awready);
    check_eq("wready", 64'd0, axil_rsp.wready);
    check_eq("arready", 64'd0, axil_rsp.arready);
    check_eq("bvalid", 64'd0, axil_rsp.bvalid);
    check_eq("rvalid", 64'd0, axil_rsp.rvalid);
    check_eq("sys_intr", 64'd0, sys_intr);
    check_eq("led", 64'hff, led);
    // flag bits only, intr bit set so no ack
    wdata = rand_bits(8) | 32'h08;
    write_reg(ethpipe_regs_pkg::ADDR_STATUS, wdata, 4'hf);
    read_reg(ethpipe_regs_pkg::ADDR_STATUS, data, smp);
    check_eq("status", wdata & 32'hf7, data);
    check_eq("led after status write", 8'(~wdata[7:0] | 8'h08), led);
    end_test();
  endtask

  task automatic register_access();
    logic [31:0] clr_m;
    logic [31:0] set_m;
    logic [31:0] wdata;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [63:0] smp;
    logic [7:0]  holes [4];
    start_test("registers");
    clr_m = MOD_RST;
    set_m = MOD_RST;
    holes = '{8'h0c, 8'h18, 8'h40, 8'hfc};
    read_reg(ethpipe_regs_pkg::ADDR_CLR_VAL, data, smp);
    check_eq("clr reset value", clr_m, data);
    read_reg(ethpipe_regs_pkg::ADDR_SET_VAL, data, smp);
    check_eq("set reset value", set_m, data);
    repeat (6) begin
      wdata = rand_bits(32);
      strb  = 4'(rand_bits(4));
      write_reg(ethpipe_regs_pkg::ADDR_CLR_VAL, wdata, strb);
      clr_m = merge_lanes(clr_m, wdata, strb);
      read_reg(ethpipe_regs_pkg::ADDR_CLR_VAL, data, smp);
      check_eq("clr value", clr_m, data);
      wdata = rand_bits(32);
      strb  = 4'(rand_bits(4));
      write_reg(ethpipe_regs_pkg::ADDR_SET_VAL, wdata, strb);
      set_m = merge_lanes(set_m, wdata, strb);
      read_reg(ethpipe_regs_pkg::ADDR_SET_VAL, data, smp);
      check_eq("set value", set_m, data);
    end
    foreach (holes[i]) begin
      read_reg(holes[i], data, smp);
      check_eq($sformatf("unmapped 0x%02h", holes[i]), 64'd0, data);
    end
    end_test();
  endtask

  task automatic counter_reads();
    logic [31:0] data;
    logic [63:0] smp;
    logic [63:0] hi_smp;
    start_test("counter");
    repeat (3) begin
      repeat (rand_bits(4)) @(posedge clk_125);
      read_reg(ethpipe_regs_pkg::ADDR_CNT_LO, data, smp);
      check_eq("counter low", smp[31:0], data);
      read_reg(ethpipe_regs_pkg::ADDR_CNT_HI, data, hi_smp);
      check_eq("counter high shadow", smp[63:32], data);
    end
    end_test();
  endtask

  task automatic timestamp_capture();
    logic [3:0]  mask;
    logic [63:0] req_cyc;
    logic [63:0] smp;
    logic [47:0] stamp;
    logic [31:0] lo;
    logic [31:0] hi;
    int          rank;
    start_test("capture");
    for (int r = 0; r < 7; r++) begin
      // lone requests first, then groups
      if (r < 4) begin
        mask = 4'(1 << r);
      end else if (r == 4) begin
        mask = 4'hf;
      end else begin
        mask = 4'(rand_bits(4));
        if (mask == '0) begin
          mask = 4'b1010;
        end
      end
      @(posedge clk_125);
      time_req <= mask;
      @(negedge clk_125);
      req_cyc = cyc;
      @(posedge clk_125);
      time_req <= '0;
      // pending fill plus one slot per cycle
      repeat (ethpipe_regs_pkg::NUM_SLOTS + 3) @(posedge clk_125);
      rank = 0;
      for (int s = 0; s < ethpipe_regs_pkg::NUM_SLOTS; s++) begin
        if (mask[s]) begin
          read_reg(8'(ethpipe_regs_pkg::ADDR_SLOT_BASE + 8 * s), lo, smp);
          read_reg(8'(ethpipe_regs_pkg::ADDR_SLOT_BASE + 8 * s + 4), hi, smp);
          stamp = 48'(req_cyc + rank);
          check_eq($sformatf("mask %b slot %0d low", mask, s), stamp[31:0], lo);
          check_eq($sformatf("mask %b slot %0d high", mask, s), stamp[47:32], hi);
          rank++;
        end
      end
    end
    end_test();
  endtask

  // lead = negedges until the level shows, count = negedges it lasts
  task automatic run_length(input logic level, output int lead, output int count);
    lead  = 0;
    count = 0;
    @(negedge clk_125);
    while (sys_intr !== level && lead < HS_LIMIT) begin
      @(negedge clk_125);
      lead++;
    end
    while (sys_intr === level && count < 4 * HS_LIMIT) begin
      if (level) begin
        check_eq("led intr bit while high", 64'd0, led[ethpipe_regs_pkg::INTR_BIT]);
      end
      count++;
      @(negedge clk_125);
    end
  endtask

  task automatic interrupt_moderation();
    logic [31:0] s_val;
    logic [31:0] c_val;
    int          lead;
    int          run;
    start_test("interrupt");
    s_val = 32'd2 + rand_bits(3);
    c_val = 32'd8 + rand_bits(4);
    write_reg(ethpipe_regs_pkg::ADDR_SET_VAL, s_val, 4'hf);
    write_reg(ethpipe_regs_pkg::ADDR_CLR_VAL, c_val, 4'hf);
    @(posedge clk_125);
    event_req <= 1'b1;
    @(posedge clk_125);
    event_req <= 1'b0;
    run_length(1'b1, lead, run);
    check_eq("flag delay after event", 64'd0, lead);
    check_eq("flag high cycles", s_val + 1, run);
    // event held, ack opens the hold-off window
    @(posedge clk_125);
    event_req <= 1'b1;
    repeat (3) @(negedge clk_125);
    check_eq("flag with event held", 64'd1, sys_intr);
    fork
      write_reg(ethpipe_regs_pkg::ADDR_STATUS, 32'h0, 4'h1);
      run_length(1'b0, lead, run);
    join
    check_eq("flag low cycles after ack", c_val + 1, run);
    @(posedge clk_125);
    event_req <= 1'b0;
    end_test();
  endtask

  initial begin
    clk_125      = 1'b0;
    sys_rst      = 1'b1;
    axil_req     = '0;
    event_req    = 1'b0;
    time_req     = '0;
    lfsr_q       = LFSR_SEED;
    test_errs    = 0;
    assert_fails = 0;
    assert_base  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk_125);
    sys_rst <= 1'b0;
    @(negedge clk_125);
    reset_and_handshake();
    register_access();
    counter_reads();
    timestamp_capture();
    interrupt_moderation();
    repeat (4) @(posedge clk_125);
    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- time_capture.sv
`timescale 1ns/1ps

module time_capture (
  input  logic                                       clk_125,
  input  logic                                       sys_rst,
  input  logic [ethpipe_regs_pkg::NUM_SLOTS-1:0]     time_req_i,
  output logic [ethpipe_regs_pkg::COUNTER_W-1:0]     counter_o,
  output ethpipe_regs_pkg::slot_array_t              slots_o
);

  logic [ethpipe_regs_pkg::COUNTER_W-1:0] counter_q;
  logic [ethpipe_regs_pkg::NUM_SLOTS-1:0] req_q;
  logic [ethpipe_regs_pkg::NUM_SLOTS-1:0] pending_q;
  logic [ethpipe_regs_pkg::NUM_SLOTS-1:0] service;
  logic [ethpipe_regs_pkg::STAMP_W-1:0]   stamp;
  ethpipe_regs_pkg::slot_array_t          slots_q;

  // lowest pending slot wins
  assign service = pending_q & (~pending_q + 1'b1);

  // back out the request pipeline delay
  assign stamp = counter_q[ethpipe_regs_pkg::STAMP_W-1:0] -
                 ethpipe_regs_pkg::CAPTURE_OFFSET;

  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      counter_q <= '0;
      req_q     <= '0;
      pending_q <= '0;
    end else begin
      counter_q <= counter_q + 1'b1;
      req_q     <= time_req_i;
      pending_q <= (pending_q & ~service) | req_q;
    end
  end

  // ----------------------------------------
  // slot storage
  // ----------------------------------------
  always_ff @(posedge clk_125) begin
    for (int k = 0; k < ethpipe_regs_pkg::NUM_SLOTS; k++) begin
      if (service[k]) begin
        slots_q[k] <= stamp;
      end
    end
  end

  assign counter_o = counter_q;
  assign slots_o   = slots_q;

endmodule
